// ==== Makefile ====
# Verilator build and run for the row buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_awe_row_buffers
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) source/row_buffer_defs.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
	    echo "Simulation failed, see $(LOG)"; \
	    exit 1; \
	fi
	@if ! grep -q "Test OK" $(LOG); then \
	    echo "No verdict found in $(LOG)"; \
	    exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+source
source/row_buffer_pkg.sv
source/prime_writer.sv
source/row_bank_ram.sv
source/window_reader.sv
source/awe_row_buffers.sv
verif/row_buffer_checker.sv
verif/tb_awe_row_buffers.sv

// ==== source/awe_row_buffers.sv ====
`default_nettype none

`include "row_buffer_defs.svh"

module awe_row_buffers (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        prime,
    input  logic                        active,
    input  logic                        pixel_valid,
    input  logic [1:0]                  input_row,
    input  logic [`COL_WIDTH-1:0]       input_col,
    input  logic [`COL_WIDTH-1:0]       num_input_cols,
    input  logic [`PIXEL_WIDTH-1:0]     pixel_datain,
    input  logic [1:0]                  gray_code,
    input  row_buffer_pkg::seq_word_u   seq_datain,
    output row_buffer_pkg::pixel_quad_t pixel_dataout,
    output logic                        dataout_valid
);

    import row_buffer_pkg::*;

    bank_wr_t                bank_wr      [`NUM_BANKS];
    bank_rd_t                bank_rd      [`NUM_BANKS];
    logic [`PIXEL_WIDTH-1:0] bank_dataout [`NUM_BANKS];

    // Priming writes
    prime_writer prime_writer_inst (
        .clk            (clk),
        .rst            (rst),
        .prime          (prime),
        .pixel_valid    (pixel_valid),
        .input_row      (input_row),
        .input_col      (input_col),
        .num_input_cols (num_input_cols),
        .pixel_datain   (pixel_datain),
        .bank_wr        (bank_wr)
    );

    ////////////////////
    // Row banks
    ////////////////////

    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
        row_bank_ram row_bank_ram_inst (
            .clk     (clk),
            .wr      (bank_wr[i]),
            .rd      (bank_rd[i]),
            .dataout (bank_dataout[i])
        );
    end

    // Sequencer driven reads
    window_reader window_reader_inst (
        .clk           (clk),
        .rst           (rst),
        .active        (active),
        .gray_code     (gray_code),
        .seq_datain    (seq_datain),
        .bank_dataout  (bank_dataout),
        .bank_rd       (bank_rd),
        .pixel_dataout (pixel_dataout),
        .dataout_valid (dataout_valid)
    );

endmodule

`default_nettype wire

// ==== source/prime_writer.sv ====
`default_nettype none

`include "row_buffer_defs.svh"

module prime_writer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     prime,
    input  logic                     pixel_valid,
    input  logic [1:0]               input_row,
    input  logic [`COL_WIDTH-1:0]    input_col,
    input  logic [`COL_WIDTH-1:0]    num_input_cols,
    input  logic [`PIXEL_WIDTH-1:0]  pixel_datain,
    output row_buffer_pkg::bank_wr_t bank_wr [`NUM_BANKS]
);

    logic [`NUM_BANKS-1:0]       bank_sel;
    logic                        half_sel;
    logic                        col_ok;
    logic                        accept;

    logic [`NUM_BANKS-1:0]       wren_q;
    logic [`BANK_ADDR_WIDTH-1:0] addr_q;
    logic [`PIXEL_WIDTH-1:0]     data_q;

    ////////////////////
    // Row to bank mapping
    ////////////////////

    always_comb begin
        case (input_row)
            2'd0:    bank_sel = 4'b1111;
            2'd1:    bank_sel = 4'b1010;
            2'd2:    bank_sel = 4'b0101;
            default: bank_sel = 4'b0000;
        endcase
    end

    // Row 0 sits in the low half, rows 1 and 2 in the high half
    assign half_sel = (input_row != 2'd0);
    assign col_ok   = (input_col <= num_input_cols);
    assign accept   = prime && pixel_valid && col_ok;

    ////////////////////
    // Registered request
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wren_q <= '0;
        end else if (accept) begin
            wren_q <= bank_sel;
        end else begin
            wren_q <= '0;
        end
    end

    // Payload follows any priming strobe
    always_ff @(posedge clk) begin
        if (prime && pixel_valid) begin
            addr_q <= {half_sel, input_col};
            data_q <= pixel_datain;
        end
    end

    // Same address and data to every bank, enables differ
    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_wr
        assign bank_wr[i].wren = wren_q[i];
        assign bank_wr[i].addr = addr_q;
        assign bank_wr[i].data = data_q;
    end

endmodule

`default_nettype wire

// ==== source/row_bank_ram.sv ====
`default_nettype none

`include "row_buffer_defs.svh"

module row_bank_ram (
    input  logic                     clk,
    input  row_buffer_pkg::bank_wr_t wr,
    input  row_buffer_pkg::bank_rd_t rd,
    output logic [`PIXEL_WIDTH-1:0]  dataout
);

    // One pixel row per half
    logic [`PIXEL_WIDTH-1:0] mem [`BANK_DEPTH];

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (wr.wren) begin
            mem[wr.addr] <= wr.data;
        end
    end

    ////////////////////
    // Registered read port
    ////////////////////

    // Holds the last word while rden is low
    always_ff @(posedge clk) begin
        if (rd.rden) begin
            dataout <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/row_buffer_defs.svh ====
`ifndef ROW_BUFFER_DEFS_SVH
`define ROW_BUFFER_DEFS_SVH

////////////////////
// Pixel and memory geometry
////////////////////

// One pixel as stored in a bank
`define PIXEL_WIDTH     18

// Words per bank, low half and high half
`define BANK_DEPTH      1024
`define BANK_ADDR_WIDTH 10

// Column index, one bit narrower than a bank address
`define COL_WIDTH       9

`define NUM_BANKS       4

////////////////////
// Sequencer and output words
////////////////////

`define SEQ_WIDTH       20
`define DATAOUT_WIDTH   72

`endif

// ==== source/row_buffer_pkg.sv ====
`default_nettype none

`include "row_buffer_defs.svh"

package row_buffer_pkg;

    // Write request for one bank
    typedef struct packed {
        logic                        wren;
        logic [`BANK_ADDR_WIDTH-1:0] addr;
        logic [`PIXEL_WIDTH-1:0]     data;
    } bank_wr_t;

    // Read request for one bank
    typedef struct packed {
        logic                        rden;
        logic [`BANK_ADDR_WIDTH-1:0] addr;
    } bank_rd_t;

    ////////////////////
    // Sequencer word views
    ////////////////////

    // Even pair reads half_sel and the full column
    typedef struct packed {
        logic                                 half_sel;
        logic [`COL_WIDTH-1:0]                col_even;
        logic [`SEQ_WIDTH-`COL_WIDTH-2:0]     unused;
    } seq_even_t;

    // Odd pair builds its lsb from parity and col_odd_lsb
    typedef struct packed {
        logic                                 half_sel;
        logic [`SEQ_WIDTH-`COL_WIDTH-3:0]     unused;
        logic [`COL_WIDTH-2:0]                col_odd_hi;
        logic                                 parity;
        logic                                 col_odd_lsb;
    } seq_odd_t;

    typedef union packed {
        seq_even_t even;
        seq_odd_t  odd;
    } seq_word_u;

    // Four read pixels, one lane per bank
    typedef struct packed {
        logic [`PIXEL_WIDTH-1:0] bank3;
        logic [`PIXEL_WIDTH-1:0] bank2;
        logic [`PIXEL_WIDTH-1:0] bank1;
        logic [`PIXEL_WIDTH-1:0] bank0;
    } pixel_quad_t;

endpackage

`default_nettype wire

// ==== source/window_reader.sv ====
`default_nettype none

`include "row_buffer_defs.svh"

module window_reader (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        active,
    input  logic [1:0]                  gray_code,
    input  row_buffer_pkg::seq_word_u   seq_datain,
    input  logic [`PIXEL_WIDTH-1:0]     bank_dataout [`NUM_BANKS],
    output row_buffer_pkg::bank_rd_t    bank_rd [`NUM_BANKS],
    output row_buffer_pkg::pixel_quad_t pixel_dataout,
    output logic                        dataout_valid
);

    import row_buffer_pkg::*;

    logic [`BANK_ADDR_WIDTH-1:0] even_addr;
    logic [`BANK_ADDR_WIDTH-1:0] odd_addr;
    logic [`BANK_ADDR_WIDTH-1:0] even_addr_q;
    logic [`BANK_ADDR_WIDTH-1:0] odd_addr_q;

    // Bit 0 is the read request stage, bit 1 the RAM output stage
    logic [1:0]                  valid_sr;
    logic [`DATAOUT_WIDTH-1:0]   ram_word;

    ////////////////////
    // Address decode
    ////////////////////

    // gray_code bit 0 flips the even pair half, bit 1 the odd pair half
    assign even_addr = {seq_datain.even.half_sel ^ gray_code[0],
                        seq_datain.even.col_even};

    assign odd_addr  = {seq_datain.odd.half_sel ^ gray_code[1],
                        seq_datain.odd.col_odd_hi,
                        seq_datain.odd.parity | seq_datain.odd.col_odd_lsb};

    always_ff @(posedge clk) begin
        if (active) begin
            even_addr_q <= even_addr;
            odd_addr_q  <= odd_addr;
        end
    end

    // Banks 0 and 2 take the even address, 1 and 3 the odd one
    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_rd
        assign bank_rd[i].rden = valid_sr[0];
        assign bank_rd[i].addr = (i % 2 == 0) ? even_addr_q : odd_addr_q;
    end

    ////////////////////
    // Valid pipeline
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr      <= '0;
            dataout_valid <= 1'b0;
        end else begin
            valid_sr      <= {valid_sr[0], active};
            dataout_valid <= valid_sr[1];
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    assign ram_word = {bank_dataout[3], bank_dataout[2],
                       bank_dataout[1], bank_dataout[0]};

    // Only words that came from a real read are captured
    always_ff @(posedge clk) begin
        if (valid_sr[1]) begin
            pixel_dataout <= pixel_quad_t'(ram_word);
        end
    end

endmodule

`default_nettype wire

// ==== verif/row_buffer_checker.sv ====
`default_nettype none

`include "row_buffer_defs.svh"

module row_buffer_checker (
    input logic                        clk,
    input logic                        rst,
    input row_buffer_pkg::pixel_quad_t pixel_dataout,
    input logic                        dataout_valid
);

    import row_buffer_pkg::*;

    // Cycles from driving a sequencer word to dataout_valid
    localparam int LATENCY = 3;

    typedef struct packed {
        logic [31:0] sent;
        pixel_quad_t word;
    } expect_t;

    expect_t     expect_q [$];
    logic [31:0] cycle = '0;
    logic        armed = 1'b0;
    int          error_count = 0;
    int          check_count = 0;

    // Edge counter, and a reset view that is stable at the falling edge
    always @(posedge clk) begin
        cycle <= cycle + 1;
        armed <= !rst;
    end

    task automatic expect_word(input pixel_quad_t word);
        expect_t entry;
        entry.sent = cycle;
        entry.word = word;
        expect_q.push_back(entry);
    endtask

    function automatic int pending();
        return expect_q.size();
    endfunction

    ////////////////////
    // Output compare
    ////////////////////

    always @(negedge clk) begin
        expect_t head;
        if (armed) begin
            if (dataout_valid === 1'b1) begin
                if (expect_q.size() == 0) begin
                    $display("error at %0t: dataout_valid high with no read outstanding",
                             $time);
                    error_count++;
                end else begin
                    head = expect_q.pop_front();
                    check_count++;
                    if (cycle - head.sent != LATENCY) begin
                        $display("error at %0t: dataout_valid came %0d cycles after the word",
                                 $time, cycle - head.sent);
                        error_count++;
                    end
                    if (pixel_dataout !== head.word) begin
                        $display("mismatch at %0t: pixel_dataout got %h expected %h",
                                 $time, pixel_dataout, head.word);
                        error_count++;
                    end
                end
            end else if (dataout_valid !== 1'b0) begin
                $display("error at %0t: dataout_valid is unknown", $time);
                error_count++;
            end else if (expect_q.size() != 0 && cycle - expect_q[0].sent > LATENCY) begin
                // Drop the lost word so later reads still line up
                $display("error at %0t: no dataout_valid for the word sent at cycle %0d",
                         $time, expect_q[0].sent);
                error_count++;
                void'(expect_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/row_buffer_patterns.hex ====
// Prime: 1 row col(3) pixel(5) num_input_cols(3) then zeros
// Read: 2 gray seq(5) then expected pixels bank3 bank2 bank1 bank0 (5 each)
// End of test: 3 test_id(2) then zeros, a record of kind 0 ends the file
// Row 0 into every bank, read back with gray_code 0
1_0_000_0a000_01f_0000000_0000000
1_0_001_0a001_01f_0000000_0000000
1_0_002_0a002_01f_0000000_0000000
1_0_003_0a003_01f_0000000_0000000
1_0_004_0a004_01f_0000000_0000000
1_0_005_0a005_01f_0000000_0000000
1_0_006_0a006_01f_0000000_0000000
1_0_007_0a007_01f_0000000_0000000
2_0_00000_0a000_0a000_0a000_0a000
2_0_01409_0a005_0a005_0a005_0a005
2_0_01c0d_0a007_0a007_0a007_0a007
3_01_00000000_00000000_00000000
// Rows 1 and 2 into the high half of their bank pairs
1_1_000_1b000_01f_0000000_0000000
1_1_001_1b001_01f_0000000_0000000
1_1_002_1b002_01f_0000000_0000000
1_1_003_1b003_01f_0000000_0000000
1_2_000_2c000_01f_0000000_0000000
1_2_001_2c001_01f_0000000_0000000
1_2_002_2c002_01f_0000000_0000000
1_2_003_2c003_01f_0000000_0000000
2_3_00804_1b002_2c002_1b002_2c002
2_0_00804_0a002_0a002_0a002_0a002
2_3_00401_1b001_2c001_1b001_2c001
2_3_00c05_1b003_2c003_1b003_2c003
3_02_00000000_00000000_00000000
// Columns past num_input_cols and row 3 are dropped
1_0_003_3ffff_002_0000000_0000000
1_1_003_3eeee_002_0000000_0000000
1_0_002_0a0f2_002_0000000_0000000
1_3_004_3dddd_01f_0000000_0000000
2_0_00c05_0a003_0a003_0a003_0a003
2_3_00c05_1b003_2c003_1b003_2c003
2_0_00804_0a0f2_0a0f2_0a0f2_0a0f2
2_0_01008_0a004_0a004_0a004_0a004
3_03_00000000_00000000_00000000
// Same word, each gray_code value
2_1_00401_0a001_2c001_0a001_2c001
2_2_00401_1b001_0a001_1b001_0a001
2_0_00401_0a001_0a001_0a001_0a001
2_3_00401_1b001_2c001_1b001_2c001
3_04_00000000_00000000_00000000
// Odd lsb from parity and col_odd_lsb
2_2_00004_1b002_0a000_1b002_0a000
2_2_00005_1b003_0a000_1b003_0a000
2_2_00006_1b003_0a000_1b003_0a000
2_2_00007_1b003_0a000_1b003_0a000
3_05_00000000_00000000_00000000
// Back to back mix
2_0_0180c_0a006_0a006_0a006_0a006
2_0_00401_0a001_0a001_0a001_0a001
2_0_01008_0a004_0a004_0a004_0a004
2_0_01c0d_0a007_0a007_0a007_0a007
2_3_00000_1b000_2c000_1b000_2c000
2_1_00c05_0a003_2c003_0a003_2c003
3_06_00000000_00000000_00000000
0_00_00000000_00000000_00000000

// ==== verif/tb_awe_row_buffers.sv ====
`default_nettype none

`include "row_buffer_defs.svh"

module tb_awe_row_buffers;

    import row_buffer_pkg::*;

    localparam int MAX_RECORDS   = 128;
    localparam int DRAIN_TIMEOUT = 16;

    logic                    clk;
    logic                    rst;
    logic                    prime;
    logic                    active;
    logic                    pixel_valid;
    logic [1:0]              input_row;
    logic [`COL_WIDTH-1:0]   input_col;
    logic [`COL_WIDTH-1:0]   num_input_cols;
    logic [`PIXEL_WIDTH-1:0] pixel_datain;
    logic [1:0]              gray_code;
    seq_word_u               seq_datain;
    pixel_quad_t             pixel_dataout;
    logic                    dataout_valid;

    // One record per line of the pattern file
    logic [107:0]            patterns [MAX_RECORDS];
    logic [31:0]             lfsr;
    logic                    timed_out;
    int                      tests_run;
    int                      errors_before;
    int                      checks_before;

    awe_row_buffers awe_row_buffers_inst (
        .clk            (clk),
        .rst            (rst),
        .prime          (prime),
        .active         (active),
        .pixel_valid    (pixel_valid),
        .input_row      (input_row),
        .input_col      (input_col),
        .num_input_cols (num_input_cols),
        .pixel_datain   (pixel_datain),
        .gray_code      (gray_code),
        .seq_datain     (seq_datain),
        .pixel_dataout  (pixel_dataout),
        .dataout_valid  (dataout_valid)
    );

    row_buffer_checker checker_inst (
        .clk           (clk),
        .rst           (rst),
        .pixel_dataout (pixel_dataout),
        .dataout_valid (dataout_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_gap(output logic [1:0] gap);
        gap = '0;
        for (int i = 0; i < 2; i++) begin
            gap  = {gap[0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic prime_pixel(input logic [107:0] rec);
        logic [1:0] gap;
        active         = 1'b0;
        prime          = 1'b1;
        pixel_valid    = 1'b1;
        input_row      = rec[101:100];
        input_col      = rec[96:88];
        pixel_datain   = rec[85:68];
        num_input_cols = rec[64:56];
        @(negedge clk);
        pixel_valid = 1'b0;
        random_gap(gap);
        repeat (gap) @(negedge clk);
    endtask

    // Consecutive read records keep active high, so they go back to back
    task automatic send_read(input logic [107:0] rec);
        pixel_quad_t expected;
        prime          = 1'b0;
        pixel_valid    = 1'b0;
        active         = 1'b1;
        gray_code      = rec[101:100];
        seq_datain     = rec[99:80];
        expected.bank3 = rec[77:60];
        expected.bank2 = rec[57:40];
        expected.bank1 = rec[37:20];
        expected.bank0 = rec[17:0];
        checker_inst.expect_word(expected);
        @(negedge clk);
    endtask

    task automatic finish_test(input logic [7:0] id);
        int waited;
        int left;
        active = 1'b0;
        waited = 0;
        while (checker_inst.pending() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        left = checker_inst.pending();
        @(negedge clk);
        if (left != 0) begin
            $display("timeout: %0d reads of test %0d still outstanding after %0d cycles",
                     left, id, waited);
            timed_out = 1'b1;
        end else begin
            tests_run++;
            $display("test %0d done: %0d reads checked, %0d errors", id,
                     checker_inst.check_count - checks_before,
                     checker_inst.error_count - errors_before);
            checks_before = checker_inst.check_count;
            errors_before = checker_inst.error_count;
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        logic [107:0] rec;
        int           idx;
        logic         done;
        rst            = 1'b1;
        prime          = 1'b0;
        // Reads requested during reset must never reach dataout_valid
        active         = 1'b1;
        pixel_valid    = 1'b0;
        input_row      = '0;
        input_col      = '0;
        num_input_cols = '0;
        pixel_datain   = '0;
        gray_code      = '0;
        seq_datain     = '0;
        lfsr           = 32'ha053_4c5f;
        timed_out      = 1'b0;
        tests_run      = 0;
        errors_before  = 0;
        checks_before  = 0;
        $readmemh("verif/row_buffer_patterns.hex", patterns);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst    = 1'b0;
        active = 1'b0;
        idx    = 0;
        done   = 1'b0;
        while (!done && idx < MAX_RECORDS) begin
            rec = patterns[idx];
            idx++;
            case (rec[107:104])
                4'h1:    prime_pixel(rec);
                4'h2:    send_read(rec);
                4'h3:    finish_test(rec[103:96]);
                default: done = 1'b1;
            endcase
            if (timed_out) begin
                done = 1'b1;
            end
        end
        $display("%0d tests, %0d reads checked, %0d errors", tests_run,
                 checker_inst.check_count, checker_inst.error_count);
        if (!timed_out && tests_run > 0 && checker_inst.error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
